// File: Bender.yml
package:
  name: vliw_core

sources:
  - files:
      - verilog/vliw_pkg.sv
      - verilog/gpr_file.sv
      - verilog/float_less.sv
      - verilog/bundle_decode.sv
      - verilog/exec_lane.sv
      - verilog/dmem_arbiter.sv
      - verilog/data_mem.sv
      - verilog/vliw_core.sv
  - target: test
    files:
      - tests/vliw_core_props.sv
      - tests/vliw_core_tb.sv

// File: all.f
verilog/vliw_pkg.sv
verilog/gpr_file.sv
verilog/float_less.sv
verilog/bundle_decode.sv
verilog/exec_lane.sv
verilog/dmem_arbiter.sv
verilog/data_mem.sv
verilog/vliw_core.sv
tests/vliw_core_props.sv
tests/vliw_core_tb.sv

// File: tests/vliw_core_props.sv
`timescale 1ns/100ps

module vliw_core_props import vliw_pkg::*; (
    input logic       clk,
    input logic       rstn,
    input logic       stall,
    input logic       branch_flag,
    input gpr_write_t wb_upper,
    input gpr_write_t wb_lower,
    input gpr_write_t wb_load
);

    int unsigned fail_count = 0;

    // A port conflict costs exactly one cycle and freezes both lanes
    stall_single: assert property (@(posedge clk) disable iff (!rstn)
                                   stall |=> !stall && $stable(wb_upper) &&
                                             $stable(wb_lower))
        else begin
            fail_count++;
            $error("stall high for two cycles in a row or lanes moved during stall");
        end

    branch_single: assert property (@(posedge clk) disable iff (!rstn)
                                    branch_flag |=> !branch_flag)
        else begin
            fail_count++;
            $error("branch_flag high for two cycles in a row");
        end

    reset_quiet: assert property (@(posedge clk)
                                  !rstn |=> !stall && !branch_flag && !wb_upper.en &&
                                            !wb_lower.en && !wb_load.en)
        else begin
            fail_count++;
            $error("control or write-back active in the cycle after reset");
        end

endmodule

// File: tests/vliw_core_tb.sv
`timescale 1ns/100ps

module vliw_core_tb import vliw_pkg::*;;

    logic       clk = 1'b0;
    logic       rstn;
    word_t      pc;
    bundle_t    inst;
    logic       hold;
    gpr_write_t wb_upper;
    gpr_write_t wb_lower;
    gpr_write_t wb_load;
    logic       branch_flag;
    word_t      branch_pc;
    logic       stall;
    logic [7:0] uart_wdata;

    integer seed;
    int     cycles = 0;
    word_t  model_regs [32];

    vliw_core vliw_core_i (
        .clk, .rstn, .pc, .inst, .hold, .wb_upper, .wb_lower, .wb_load,
        .branch_flag, .branch_pc, .stall, .uart_wdata
    );

    bind vliw_core vliw_core_props vliw_core_props_i (
        .clk, .rstn, .stall, .branch_flag, .wb_upper, .wb_lower, .wb_load
    );

    always #10 clk = ~clk;

    // Roughly four times the length of all tests
    always @(posedge clk) begin
        if (cycles >= 400) begin
            $display("Error: run timed out after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $fatal(1);
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_wb(string what, gpr_write_t got, gpr_write_t exp);
        if (got.en !== exp.en || (exp.en && (got.rt !== exp.rt || got.data !== exp.data))) begin
            $display("Fail %0t: %s got en=%b rt=%0d data=%h, expected en=%b rt=%0d data=%h",
                     $time, what, got.en, got.rt, got.data, exp.en, exp.rt, exp.data);
            stop_run();
        end
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(string what, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    function automatic slot_inst_t imm_slot(opcode_t op, reg_idx_t rt, reg_idx_t ra,
                                            logic [15:0] imm);
        slot_inst_t s;
        s.op      = op;
        s.rt      = rt;
        s.ra      = ra;
        s.src.imm = imm;
        return s;
    endfunction

    function automatic slot_inst_t reg_slot(opcode_t op, reg_idx_t rt, reg_idx_t ra,
                                            reg_idx_t rb);
        return imm_slot(op, rt, ra, {rb, 11'b0});
    endfunction

    // 26-bit direct target spread over rt, ra and imm
    function automatic slot_inst_t far_slot(opcode_t op, logic [25:0] t);
        return imm_slot(op, t[25:21], t[20:16], t[15:0]);
    endfunction

    function automatic logic squashes(opcode_t op);
        return op inside {Jump, Bl, Blr, Blrr, Beq, Bne, Blt, Ble, Bge, Bgt, Outll};
    endfunction

    function automatic logic cond_taken(opcode_t br, logic eq, logic less);
        case (br)
            Beq    : return eq;
            Bne    : return !eq;
            Blt    : return less;
            Ble    : return eq || less;
            Bge    : return !less;
            Bgt    : return !(eq || less);
            default: return 1'b1;
        endcase
    endfunction

    // Expected write-back of one slot
    function automatic gpr_write_t alu_model(slot_inst_t s);
        word_t      a;
        word_t      b;
        word_t      si;
        gpr_write_t w;
        a  = model_regs[s.ra];
        b  = model_regs[s.src.rb.idx];
        si = {{16{s.src.imm[15]}}, s.src.imm};
        w  = '{en: 1'b1, rt: s.rt, data: '0};
        case (s.op)
            Add    : w.data = a + b;
            Sub    : w.data = a - b;
            Addi   : w.data = a + si;
            Subi   : w.data = a - si;
            Srawi  : w.data = $signed(a) >>> si[4:0];
            Slawi  : w.data = a << si[4:0];
            Xor    : w.data = a ^ b;
            And    : w.data = a & b;
            Li     : w.data = si;
            default: w.en = 1'b0;
        endcase
        return w;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic run_bundle(slot_inst_t up, slot_inst_t lo);
        gpr_write_t exp_up;
        gpr_write_t exp_lo;
        exp_up = alu_model(up);
        exp_lo = squashes(up.op) ? '0 : alu_model(lo);
        inst = {up, lo};
        tick();
        inst = '0;
        check_wb("wb_upper before result", wb_upper, '0);
        check_wb("wb_lower before result", wb_lower, '0);
        tick();
        check_wb("wb_upper", wb_upper, exp_up);
        check_wb("wb_lower", wb_lower, exp_lo);
        tick();
        check_wb("wb_upper after result", wb_upper, '0);
        check_wb("wb_lower after result", wb_lower, '0);
        if (exp_up.en) begin
            model_regs[exp_up.rt] = exp_up.data;
        end
        if (exp_lo.en) begin
            model_regs[exp_lo.rt] = exp_lo.data;
        end
    endtask

    task automatic mem_bundle(slot_inst_t up, slot_inst_t lo, logic dual,
                              gpr_write_t first, gpr_write_t second);
        inst = {up, lo};
        tick();
        inst = '0;
        check_bit("stall before access", stall, 1'b0);
        tick();
        check_bit("stall", stall, dual);
        check_wb("wb_load first", wb_load, first);
        tick();
        check_bit("stall one cycle later", stall, 1'b0);
        check_wb("wb_load second", wb_load, second);
        tick();
        check_wb("wb_load idle", wb_load, '0);
    endtask

    task automatic branch_case(slot_inst_t up, slot_inst_t lo, word_t pc_in, logic taken,
                               word_t target, gpr_write_t exp_up);
        pc   = pc_in;
        inst = {up, lo};
        tick();
        check_bit("branch_flag", branch_flag, taken);
        if (taken) begin
            check_word("branch_pc", branch_pc, target);
            // Offered in the flag cycle and dropped by decode
            inst = {imm_slot(Li, 20, 0, 16'h1234), imm_slot(Li, 21, 0, 16'h5678)};
        end else begin
            inst = '0;
        end
        tick();
        inst = '0;
        check_bit("branch_flag one cycle later", branch_flag, 1'b0);
        check_wb("wb_upper of branch", wb_upper, exp_up);
        check_wb("wb_lower beside branch", wb_lower, '0);
        tick();
        check_wb("wb_upper after flag cycle", wb_upper, '0);
        check_wb("wb_lower after flag cycle", wb_lower, '0);
        if (exp_up.en) begin
            model_regs[exp_up.rt] = exp_up.data;
        end
    endtask

    task automatic compare_then_branch(slot_inst_t cmp, opcode_t br, logic eq, logic less);
        logic [25:0] t;
        t = $random(seed);
        run_bundle(cmp, '0);
        branch_case(far_slot(br, t), imm_slot(Li, 22, 0, 16'h0bad), $random(seed),
                    cond_taken(br, eq, less), {6'b0, t}, '0);
    endtask

    task automatic test_alu();
        logic [15:0] v [4];
        logic [15:0] k0;
        logic [15:0] k1;
        for (int i = 0; i < 4; i++) begin
            v[i] = $random(seed);
        end
        k0 = $random(seed);
        k1 = $random(seed);
        run_bundle(imm_slot(Li, 1, 0, v[0]), imm_slot(Li, 2, 0, v[1]));
        run_bundle(imm_slot(Li, 3, 0, v[2]), imm_slot(Li, 4, 0, v[3]));
        run_bundle(reg_slot(Add, 5, 1, 2), reg_slot(Sub, 6, 3, 4));
        run_bundle(imm_slot(Addi, 7, 1, k0), imm_slot(Subi, 8, 2, k1));
        run_bundle(reg_slot(Xor, 9, 3, 1), reg_slot(And, 15, 4, 2));
        run_bundle(imm_slot(Srawi, 16, 5, k0), imm_slot(Slawi, 17, 6, k1));
    endtask

    task automatic test_memory();
        logic [15:0] v0;
        logic [15:0] v1;
        gpr_write_t  first;
        gpr_write_t  second;
        v0 = $random(seed);
        v1 = $random(seed);
        run_bundle(imm_slot(Li, 10, 0, v0), imm_slot(Li, 11, 0, v1));
        mem_bundle(imm_slot(Store, 10, 0, 16'h0012), imm_slot(Store, 11, 0, 16'h0034),
                   1'b1, '0, '0);
        first  = '{en: 1'b1, rt: 5'd12, data: model_regs[10]};
        second = '{en: 1'b1, rt: 5'd13, data: model_regs[11]};
        mem_bundle(imm_slot(Load, 12, 0, 16'h0012), imm_slot(Load, 13, 0, 16'h0034),
                   1'b1, first, second);
        // Lone load, no conflict
        first = '{en: 1'b1, rt: 5'd14, data: model_regs[10]};
        mem_bundle('0, imm_slot(Load, 14, 0, 16'h0012), 1'b0, first, '0);
    endtask

    task automatic test_compare_branch();
        logic [15:0] v0;
        logic [15:0] v1;
        logic [15:0] k;
        word_t       a;
        word_t       b;
        word_t       sk;
        v0 = $random(seed);
        v1 = $random(seed);
        k  = $random(seed);
        run_bundle(imm_slot(Li, 1, 0, v0), imm_slot(Li, 2, 0, v1));
        // 1.0 and -2.0 from their upper halves
        run_bundle(imm_slot(Li, 3, 0, 16'h3f80), imm_slot(Li, 4, 0, 16'hc000));
        run_bundle(imm_slot(Slawi, 3, 3, 16), imm_slot(Slawi, 4, 4, 16));
        a  = model_regs[1];
        b  = model_regs[2];
        sk = {{16{k[15]}}, k};
        compare_then_branch(reg_slot(Cmpd, 0, 1, 1), Beq, 1'b1, 1'b0);
        compare_then_branch(reg_slot(Cmpd, 0, 1, 2), Bne, a == b, $signed(a) < $signed(b));
        compare_then_branch(imm_slot(Cmpdi, 0, 1, k), Blt, a == sk, $signed(a) < $signed(sk));
        compare_then_branch(reg_slot(Cmpd, 0, 2, 1), Ble, b == a, $signed(b) < $signed(a));
        compare_then_branch(reg_slot(Cmpf, 0, 3, 4), Bge, 1'b0, 1'b0);
        compare_then_branch(reg_slot(Cmpf, 0, 4, 3), Bgt, 1'b0, 1'b1);
    endtask

    task automatic test_jumps();
        logic [25:0] t0;
        logic [25:0] t1;
        word_t       p0;
        word_t       p1;
        slot_inst_t  lo;
        t0 = $random(seed);
        t1 = $random(seed);
        p0 = $random(seed);
        p1 = $random(seed);
        lo = imm_slot(Li, 22, 0, 16'h0101);
        branch_case(far_slot(Jump, t0), lo, p0, 1'b1, {6'b0, t0}, '0);
        branch_case(far_slot(Bl, t1), lo, p0, 1'b1, {6'b0, t1},
                    '{en: 1'b1, rt: LINK_REG, data: p0 + 32'd1});
        branch_case(imm_slot(Blr, 0, 0, 0), lo, p1, 1'b1, model_regs[31], '0);
        branch_case(imm_slot(Blrr, 1, 0, 0), lo, p1, 1'b1, model_regs[1],
                    '{en: 1'b1, rt: LINK_REG, data: p1 + 32'd1});
    endtask

    task automatic test_hold_uart();
        hold = 1'b1;
        inst = {imm_slot(Li, 20, 0, 16'h0055), imm_slot(Li, 21, 0, 16'h0066)};
        repeat (3) begin
            tick();
            check_bit("branch_flag under hold", branch_flag, 1'b0);
            check_wb("wb_upper under hold", wb_upper, '0);
            check_wb("wb_lower under hold", wb_lower, '0);
            inst = {far_slot(Jump, 26'h0000abc), imm_slot(Li, 21, 0, 16'h0066)};
        end
        hold = 1'b0;
        inst = '0;
        tick();
        check_wb("wb_upper after hold", wb_upper, '0);
        check_wb("wb_lower after hold", wb_lower, '0);
        inst = {imm_slot(Outll, 5, 0, 0), imm_slot(Li, 23, 0, 16'h0077)};
        #1;
        check_byte("uart_wdata", uart_wdata, model_regs[5][7:0]);
        run_bundle(imm_slot(Outll, 5, 0, 0), imm_slot(Li, 23, 0, 16'h0077));
    endtask

    initial begin
        seed = 32'h0e4e4fa2;
        rstn = 1'b0;
        hold = 1'b0;
        pc   = '0;
        inst = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        test_alu();
        test_memory();
        test_compare_branch();
        test_jumps();
        test_hold_uart();
        if (vliw_core_i.vliw_core_props_i.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("Error: %0d assertion failures",
                     vliw_core_i.vliw_core_props_i.fail_count);
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog/bundle_decode.sv
`timescale 1ns/100ps

module bundle_decode import vliw_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     interlock,
    input  word_t    pc,
    input  bundle_t  inst,
    output reg_idx_t upper_s_idx,
    output reg_idx_t upper_a_idx,
    output reg_idx_t upper_b_idx,
    output reg_idx_t lower_s_idx,
    output reg_idx_t lower_a_idx,
    output reg_idx_t lower_b_idx,
    input  word_t    upper_s_data,
    input  word_t    upper_a_data,
    input  word_t    upper_b_data,
    input  word_t    lower_s_data,
    input  word_t    lower_a_data,
    input  word_t    lower_b_data,
    input  word_t    link_data,
    output logic     branch_flag,
    output word_t    branch_pc,
    output lane_op_t upper_op,
    output lane_op_t lower_op,
    output mem_req_t upper_req,
    output mem_req_t lower_req,
    output logic [7:0] uart_wdata
);

    function automatic lane_op_t slot_op(opcode_t op, word_t reg_a, word_t reg_b,
                                         word_t si, word_t link_pc);
        lane_op_t r;
        r = '{srca: reg_a, srcb: si, e_type: ENop, rt_flag: 1'b0};
        case (op)
            Add, Addi   : r.e_type = EAdd;
            Sub, Subi   : r.e_type = ESub;
            Srawi       : r.e_type = ERshift;
            Slawi       : r.e_type = ELshift;
            Xor         : r.e_type = EXor;
            And         : r.e_type = EAnd;
            Li, Bl, Blrr: r.e_type = EAdd;
            default     : r.e_type = ENop;
        endcase
        if (op inside {Add, Sub, Xor, And}) begin
            r.srcb = reg_b;
        end
        if (op inside {Bl, Blrr}) begin
            r.srcb = link_pc;
        end
        if (op inside {Li, Bl, Blrr}) begin
            r.srca = '0;
        end
        r.rt_flag = op inside {Add, Sub, Addi, Subi, Srawi, Slawi, Xor, And, Li, Bl, Blrr};
        return r;
    endfunction

    function automatic mem_req_t slot_req(opcode_t op, word_t reg_a, word_t reg_s,
                                          word_t si, reg_idx_t rt);
        mem_req_t r;
        r.addr  = reg_a + si;
        r.din   = reg_s;
        r.store = (op == Store);
        r.load  = (op == Load);
        r.rt    = (op inside {Bl, Blrr}) ? LINK_REG : rt;
        return r;
    endfunction

    // {hit, eq, less}
    function automatic logic [2:0] slot_cmp(opcode_t op, word_t a, word_t b, word_t si,
                                            logic fless);
        case (op)
            Cmpd   : return {1'b1, a == b, $signed(a) < $signed(b)};
            Cmpdi  : return {1'b1, a == si, $signed(a) < $signed(si)};
            Cmpf   : return {1'b1, (a == b) || (a[30:23] == '0 && b[30:23] == '0), fless};
            default: return 3'b000;
        endcase
    endfunction

    logic       eq;
    logic       less;
    logic       conflict_q;
    logic       squash;
    logic       upper_fless;
    logic       lower_fless;
    logic       take_n;
    opcode_t    lower_code;
    word_t      upper_si;
    word_t      lower_si;
    word_t      link_pc;
    word_t      direct_pc;
    word_t      target_n;
    logic [2:0] upper_cmp;
    logic [2:0] lower_cmp;

    assign upper_s_idx = inst.upper.rt;
    assign upper_a_idx = inst.upper.ra;
    assign upper_b_idx = inst.upper.src.rb.idx;
    assign lower_s_idx = inst.lower.rt;
    assign lower_a_idx = inst.lower.ra;
    assign lower_b_idx = inst.lower.src.rb.idx;

    assign upper_si  = {{16{inst.upper.src.imm[15]}}, inst.upper.src.imm};
    assign lower_si  = {{16{inst.lower.src.imm[15]}}, inst.lower.src.imm};
    assign link_pc   = pc + 32'd1;
    assign direct_pc = {6'b0, inst.upper.rt, inst.upper.ra, inst.upper.src.imm};
    assign uart_wdata = upper_s_data[7:0];

    // Lower slot is dropped behind an upper branch or Outll
    assign squash = inst.upper.op inside {Jump, Bl, Blr, Blrr, Beq, Bne, Blt, Ble, Bge,
                                          Bgt, Outll};
    assign lower_code = squash ? Nop : inst.lower.op;

    float_less u_fless_i (.srca(upper_a_data), .srcb(upper_b_data), .result(upper_fless));
    float_less l_fless_i (.srca(lower_a_data), .srcb(lower_b_data), .result(lower_fless));

    assign upper_cmp = slot_cmp(inst.upper.op, upper_a_data, upper_b_data, upper_si,
                                upper_fless);
    assign lower_cmp = slot_cmp(lower_code, lower_a_data, lower_b_data, lower_si,
                                lower_fless);

    always_comb begin
        target_n = direct_pc;
        case (inst.upper.op)
            Jump, Bl: take_n = 1'b1;
            Blr     : take_n = 1'b1;
            Blrr    : take_n = 1'b1;
            Beq     : take_n = eq;
            Bne     : take_n = !eq;
            Blt     : take_n = less;
            Ble     : take_n = eq || less;
            Bge     : take_n = !less;
            Bgt     : take_n = !(eq || less);
            default : take_n = 1'b0;
        endcase
        if (inst.upper.op == Blr) begin
            target_n = link_data;
        end else if (inst.upper.op == Blrr) begin
            target_n = upper_s_data;
        end else if (!take_n) begin
            target_n = '0;
        end
    end

    // Mirrors the arbiter stall so the pending bundle is kept for the lanes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            conflict_q <= 1'b0;
        end else begin
            conflict_q <= (upper_req.store | upper_req.load) &&
                          (lower_req.store | lower_req.load) && !conflict_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            branch_flag       <= 1'b0;
            eq                <= 1'b0;
            less              <= 1'b0;
            upper_op.e_type   <= ENop;
            upper_op.rt_flag  <= 1'b0;
            lower_op.e_type   <= ENop;
            lower_op.rt_flag  <= 1'b0;
            upper_req.store   <= 1'b0;
            upper_req.load    <= 1'b0;
            lower_req.store   <= 1'b0;
            lower_req.load    <= 1'b0;
        end else if (!conflict_q) begin
            if (branch_flag || interlock) begin
                // Bubble
                branch_flag      <= 1'b0;
                upper_op.e_type  <= ENop;
                upper_op.rt_flag <= 1'b0;
                lower_op.e_type  <= ENop;
                lower_op.rt_flag <= 1'b0;
                upper_req.store  <= 1'b0;
                upper_req.load   <= 1'b0;
                lower_req.store  <= 1'b0;
                lower_req.load   <= 1'b0;
                if (branch_flag) begin
                    eq   <= 1'b0;
                    less <= 1'b0;
                end
            end else begin
                upper_op    <= slot_op(inst.upper.op, upper_a_data, upper_b_data, upper_si,
                                       link_pc);
                lower_op    <= slot_op(lower_code, lower_a_data, lower_b_data, lower_si,
                                       link_pc);
                upper_req   <= slot_req(inst.upper.op, upper_a_data, upper_s_data, upper_si,
                                        inst.upper.rt);
                lower_req   <= slot_req(lower_code, lower_a_data, lower_s_data, lower_si,
                                        inst.lower.rt);
                branch_flag <= take_n;
                branch_pc   <= target_n;
                if (upper_cmp[2]) begin
                    eq   <= upper_cmp[1];
                    less <= upper_cmp[0];
                end else if (lower_cmp[2]) begin
                    eq   <= lower_cmp[1];
                    less <= lower_cmp[0];
                end
            end
        end
    end

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/100ps

module data_mem import vliw_pkg::*; (
    input  logic  clk,
    input  word_t addr,
    input  word_t wdata,
    input  logic  we,
    output word_t rdata
);

    word_t mem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] index;

    // Word address wraps at the memory depth
    assign index = addr[DMEM_AW-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

// File: verilog/dmem_arbiter.sv
`timescale 1ns/100ps

module dmem_arbiter import vliw_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  mem_req_t   upper_req,
    input  mem_req_t   lower_req,
    output logic       stall,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic       mem_we,
    input  word_t      mem_rdata,
    output gpr_write_t wb_load
);

    logic     upper_act;
    logic     lower_act;
    logic     load_q;
    reg_idx_t load_rt_q;
    mem_req_t pend_req;
    mem_req_t grant_req;

    assign upper_act = upper_req.store | upper_req.load;
    assign lower_act = lower_req.store | lower_req.load;

    // Upper first, a deferred lower goes in the stall cycle
    always_comb begin
        if (stall) begin
            grant_req = pend_req;
        end else if (upper_act) begin
            grant_req = upper_req;
        end else begin
            grant_req = lower_req;
        end
    end

    assign mem_addr  = grant_req.addr;
    assign mem_wdata = grant_req.din;
    assign mem_we    = grant_req.store;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stall  <= 1'b0;
            load_q <= 1'b0;
        end else begin
            stall  <= upper_act && lower_act && !stall;
            load_q <= grant_req.load;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pend_req <= lower_req;
        end
        load_rt_q <= grant_req.rt;
    end

    assign wb_load = '{en: load_q, rt: load_rt_q, data: mem_rdata};

endmodule

// File: verilog/exec_lane.sv
`timescale 1ns/100ps

module exec_lane import vliw_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       stall,
    input  lane_op_t   op,
    input  reg_idx_t   rt,
    output gpr_write_t wb
);

    word_t result;

    always_comb begin
        case (op.e_type)
            EAdd   : result = op.srca + op.srcb;
            ESub   : result = op.srca - op.srcb;
            ERshift: result = $signed(op.srca) >>> op.srcb[4:0];
            ELshift: result = op.srca << op.srcb[4:0];
            EXor   : result = op.srca ^ op.srcb;
            EAnd   : result = op.srca & op.srcb;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb.en <= 1'b0;
        end else if (!stall) begin
            wb.en <= op.rt_flag;
        end
    end

    // Write-back payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            wb.rt   <= rt;
            wb.data <= result;
        end
    end

endmodule

// File: verilog/float_less.sv
`timescale 1ns/100ps

module float_less import vliw_pkg::*; (
    input  word_t srca,
    input  word_t srcb,
    output logic  result
);

    logic both_zero;

    assign both_zero = (srca[30:0] == '0) && (srcb[30:0] == '0);

    always_comb begin
        if (both_zero) begin
            result = 1'b0;
        end else if (srca[31] != srcb[31]) begin
            result = srca[31];
        end else if (!srca[31]) begin
            result = srca[30:0] < srcb[30:0];
        end else begin
            // Both negative, larger magnitude is smaller
            result = srca[30:0] > srcb[30:0];
        end
    end

endmodule

// File: verilog/gpr_file.sv
`timescale 1ns/100ps

module gpr_file import vliw_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  gpr_write_t wb_upper,
    input  gpr_write_t wb_lower,
    input  gpr_write_t wb_load,
    input  reg_idx_t   upper_s_idx,
    input  reg_idx_t   upper_a_idx,
    input  reg_idx_t   upper_b_idx,
    input  reg_idx_t   lower_s_idx,
    input  reg_idx_t   lower_a_idx,
    input  reg_idx_t   lower_b_idx,
    output word_t      upper_s_data,
    output word_t      upper_a_data,
    output word_t      upper_b_data,
    output word_t      lower_s_data,
    output word_t      lower_a_data,
    output word_t      lower_b_data,
    output word_t      link_data
);

    word_t regs [32];

    // Later writes win, so load beats lower beats upper
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_upper.en) begin
                regs[wb_upper.rt] <= wb_upper.data;
            end
            if (wb_lower.en) begin
                regs[wb_lower.rt] <= wb_lower.data;
            end
            if (wb_load.en) begin
                regs[wb_load.rt] <= wb_load.data;
            end
        end
    end

    assign upper_s_data = regs[upper_s_idx];
    assign upper_a_data = regs[upper_a_idx];
    assign upper_b_data = regs[upper_b_idx];
    assign lower_s_data = regs[lower_s_idx];
    assign lower_a_data = regs[lower_a_idx];
    assign lower_b_data = regs[lower_b_idx];
    assign link_data    = regs[LINK_REG];

endmodule

// File: verilog/vliw_core.sv
`timescale 1ns/100ps

module vliw_core import vliw_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  word_t      pc,
    input  bundle_t    inst,
    input  logic       hold,
    output gpr_write_t wb_upper,
    output gpr_write_t wb_lower,
    output gpr_write_t wb_load,
    output logic       branch_flag,
    output word_t      branch_pc,
    output logic       stall,
    output logic [7:0] uart_wdata
);

    reg_idx_t upper_s_idx, upper_a_idx, upper_b_idx;
    reg_idx_t lower_s_idx, lower_a_idx, lower_b_idx;
    word_t    upper_s_data, upper_a_data, upper_b_data;
    word_t    lower_s_data, lower_a_data, lower_b_data;
    word_t    link_data;
    lane_op_t upper_op, lower_op;
    mem_req_t upper_req, lower_req;
    word_t    mem_addr, mem_wdata, mem_rdata;
    logic     mem_we;
    logic     interlock;

    assign interlock = hold | stall;

    gpr_file gpr_file_i (
        .clk, .rstn, .wb_upper, .wb_lower, .wb_load,
        .upper_s_idx, .upper_a_idx, .upper_b_idx,
        .lower_s_idx, .lower_a_idx, .lower_b_idx,
        .upper_s_data, .upper_a_data, .upper_b_data,
        .lower_s_data, .lower_a_data, .lower_b_data, .link_data
    );

    bundle_decode bundle_decode_i (
        .clk, .rstn, .interlock, .pc, .inst,
        .upper_s_idx, .upper_a_idx, .upper_b_idx,
        .lower_s_idx, .lower_a_idx, .lower_b_idx,
        .upper_s_data, .upper_a_data, .upper_b_data,
        .lower_s_data, .lower_a_data, .lower_b_data, .link_data,
        .branch_flag, .branch_pc, .upper_op, .lower_op,
        .upper_req, .lower_req, .uart_wdata
    );

    exec_lane upper_lane_i (
        .clk, .rstn, .stall, .op(upper_op), .rt(upper_req.rt), .wb(wb_upper)
    );

    exec_lane lower_lane_i (
        .clk, .rstn, .stall, .op(lower_op), .rt(lower_req.rt), .wb(wb_lower)
    );

    dmem_arbiter dmem_arbiter_i (
        .clk, .rstn, .upper_req, .lower_req, .stall,
        .mem_addr, .mem_wdata, .mem_we, .mem_rdata, .wb_load
    );

    data_mem data_mem_i (
        .clk, .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(mem_rdata)
    );

endmodule

// File: verilog/vliw_pkg.sv
package vliw_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        Nop, Add, Sub, Addi, Subi, Srawi, Slawi, Xor, And, Li,
        Load, Store, Cmpd, Cmpdi, Cmpf,
        Jump, Bl, Blr, Blrr, Beq, Bne, Blt, Ble, Bge, Bgt,
        Outll
    } opcode_t;

    typedef enum logic [2:0] {
        ENop, EAdd, ESub, ERshift, ELshift, EXor, EAnd
    } exec_op_t;

    // Register b sits in the top bits of the immediate
    typedef struct packed {
        reg_idx_t    idx;
        logic [10:0] unused;
    } rb_field_t;

    typedef union packed {
        rb_field_t   rb;
        logic [15:0] imm;
    } src_field_t;

    typedef struct packed {
        opcode_t    op;
        reg_idx_t   rt;
        reg_idx_t   ra;
        src_field_t src;
    } slot_inst_t;

    typedef struct packed {
        slot_inst_t upper;
        slot_inst_t lower;
    } bundle_t;

    typedef struct packed {
        word_t    srca;
        word_t    srcb;
        exec_op_t e_type;
        logic     rt_flag;
    } lane_op_t;

    typedef struct packed {
        word_t    addr;
        word_t    din;
        logic     store;
        logic     load;
        reg_idx_t rt;
    } mem_req_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rt;
        word_t    data;
    } gpr_write_t;

    localparam reg_idx_t LINK_REG = 5'd31;
    localparam int DMEM_DEPTH = 256;
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

endpackage
